//--- logic/frontend_pkg.sv
package frontend_pkg;

  // ----------------------------------------
  // widths with a meaning
  // ----------------------------------------
  // instruction address, byte granular
  typedef logic [31:0] addr_t;
  // uncompressed instruction word
  typedef logic [31:0] instr_t;
  // 2-bit saturating branch counter
  typedef logic [1:0]  ctr_t;
  typedef logic [6:0]  opcode_t;

  // weakly not taken
  localparam ctr_t CTR_RESET = 2'b01;

  // major opcodes the scanner looks for
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;

  // ----------------------------------------
  // bundles
  // ----------------------------------------
  // request toward instruction memory
  typedef struct packed {
    addr_t addr;
  } imem_req_t;

  // data returned by instruction memory
  typedef struct packed {
    instr_t data;
  } imem_rsp_t;

  // one instruction handed to decode
  typedef struct packed {
    addr_t  pc;
    instr_t instr;
    logic   pred_taken;
  } fetch_entry_t;

  // resolved control flow from the back end
  typedef struct packed {
    logic  valid;
    logic  is_branch;
    logic  taken;
    logic  mispredict;
    addr_t pc;
    addr_t target;
  } resolve_t;

  // fetch control FSM
  typedef enum logic [1:0] {
    BOOT,
    REQ,
    WAIT,
    DROP
  } ctrl_state_e;

endpackage

//--- logic/fetch_ctrl.sv
module fetch_ctrl
  import frontend_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_ready_i,
  input  logic rsp_valid_i,
  input  logic mispredict_i,
  input  logic queue_full_slots_i,
  input  logic queue_empty_i,
  output logic req_valid_o,
  output logic accept_o,
  output logic advance_pc_o,
  output logic flush_o
);

  localparam int unsigned CW = $clog2(QUEUE_DEPTH + 1);

  ctrl_state_e state_q, state_d;

  // set when the last push may have taken the final slot
  logic full_q;
  logic queue_full;
  logic [CW-1:0] occupancy;
  logic [CW-1:0] outstanding;
  logic [CW-1:0] free_slots;

  // ----------------------------------------
  // slot accounting
  // ----------------------------------------
  // after a push at almost full the queue holds DEPTH-1 or DEPTH entries,
  // the almost-full flag tells which one
  assign queue_full = full_q & ~queue_full_slots_i & ~queue_empty_i;

  always_comb begin
    // lower bound on queue level, exact near the top
    if (queue_full) begin
      occupancy = CW'(QUEUE_DEPTH);
    end else if (queue_full_slots_i) begin
      occupancy = CW'(QUEUE_DEPTH - 1);
    end else begin
      occupancy = '0;
    end
    // one response in flight while waiting or dropping
    outstanding = CW'((state_q == WAIT) || (state_q == DROP));
    free_slots  = CW'(QUEUE_DEPTH) - occupancy - outstanding;
  end

  // ----------------------------------------
  // strobes
  // ----------------------------------------
  // a request only goes out if its response has a slot waiting
  assign req_valid_o  = (state_q == REQ) && (free_slots != '0);
  // responses in WAIT are pushed unless the same cycle redirects
  assign accept_o     = (state_q == WAIT) && rsp_valid_i && !mispredict_i;
  assign advance_pc_o = accept_o;
  assign flush_o      = mispredict_i;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // pc_gen loads the boot address in this cycle
      BOOT: state_d = REQ;
      REQ: begin
        // request taken together with a redirect belongs to the old path
        if (req_valid_o && req_ready_i) begin
          state_d = mispredict_i ? DROP : WAIT;
        end
      end
      WAIT: begin
        if (mispredict_i) begin
          state_d = rsp_valid_i ? REQ : DROP;
        end else if (rsp_valid_i) begin
          state_d = REQ;
        end
      end
      // swallow the stale response
      DROP: if (rsp_valid_i) state_d = REQ;
      default: state_d = BOOT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= BOOT;
      full_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (flush_o) begin
        full_q <= 1'b0;
      end else if (accept_o) begin
        full_q <= queue_full_slots_i;
      end else if (queue_full_slots_i || queue_empty_i) begin
        // level seen at or below DEPTH-1, no longer full
        full_q <= 1'b0;
      end
    end
  end

  // memory only answers a request that was taken
  a_no_rsp_without_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q inside {BOOT, REQ}) |-> !rsp_valid_i);

  // request held until the memory takes it, a redirect restarts it
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_o && !req_ready_i && !mispredict_i) |=> req_valid_o);

endmodule

//--- logic/pc_gen.sv
module pc_gen
  import frontend_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  addr_t boot_addr_i,
  input  logic  advance_i,
  input  addr_t next_pc_i,
  input  logic  redirect_i,
  input  addr_t redirect_pc_i,
  output addr_t pc_o
);

  // high only in the first cycle after reset release
  logic  boot_load_q;
  addr_t pc_q;

  // ----------------------------------------
  // fetch pc register
  // ----------------------------------------
  // priority
  // 1. boot address once out of reset
  // 2. redirect from the back end
  // 3. predicted next pc after an accepted response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_load_q <= 1'b1;
      pc_q        <= '0;
    end else begin
      boot_load_q <= 1'b0;
      if (boot_load_q) begin
        // boot address sampled after reset so the top can tie it freely
        pc_q <= boot_addr_i;
      end else if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (advance_i) begin
        pc_q <= next_pc_i;
      end
    end
  end

  // current request address and pc of the outstanding response
  assign pc_o = pc_q;

  // fetch addresses stay word aligned once out of boot
  a_pc_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !boot_load_q |-> (pc_q[1:0] == 2'b00));

endmodule

//--- logic/instr_scan.sv
module instr_scan
  import frontend_pkg::*;
(
  input  instr_t instr_i,
  output logic   is_branch_o,
  output logic   is_jal_o,
  output addr_t  offset_o
);

  opcode_t opcode;
  addr_t   imm_b;
  addr_t   imm_j;

  // ----------------------------------------
  // opcode decode
  // ----------------------------------------
  assign opcode      = instr_i[6:0];
  // uncompressed only, low bits are part of the opcode
  assign is_branch_o = (opcode == OPC_BRANCH);
  assign is_jal_o    = (opcode == OPC_JAL);

  // ----------------------------------------
  // immediates
  // ----------------------------------------
  // B-type, 13 bit signed, bit 0 always zero
  assign imm_b = {
    {19{instr_i[31]}},
    instr_i[31],
    instr_i[7],
    instr_i[30:25],
    instr_i[11:8],
    1'b0
  };

  // J-type, 21 bit signed, bit 0 always zero
  assign imm_j = {
    {11{instr_i[31]}},
    instr_i[31],
    instr_i[19:12],
    instr_i[20],
    instr_i[30:21],
    1'b0
  };

  // jal offset wins, otherwise the branch offset
  // only meaningful when one of the flags is set
  assign offset_o = is_jal_o ? imm_j : imm_b;

endmodule

//--- logic/branch_history.sv
module branch_history
  import frontend_pkg::*;
#(
  parameter int unsigned BHT_ENTRIES = 16
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  addr_t    lookup_pc_i,
  input  resolve_t update_i,
  output logic     taken_o
);

  localparam int unsigned IW = $clog2(BHT_ENTRIES);

  ctr_t          table_q [BHT_ENTRIES];
  logic [IW-1:0] lookup_idx;
  logic [IW-1:0] update_idx;
  logic          do_update;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  // word index, bits 1:0 are always zero
  assign lookup_idx = lookup_pc_i[IW+1:2];
  assign update_idx = update_i.pc[IW+1:2];

  // msb of the counter is the taken prediction
  assign taken_o = table_q[lookup_idx][1];

  // only conditional branches train the table
  assign do_update = update_i.valid && update_i.is_branch;

  // ----------------------------------------
  // saturating update
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        table_q[i] <= CTR_RESET;
      end
    end else if (do_update) begin
      if (update_i.taken) begin
        // count up, stop at strongly taken
        if (table_q[update_idx] != 2'b11) begin
          table_q[update_idx] <= table_q[update_idx] + 2'b01;
        end
      end else begin
        // count down, stop at strongly not taken
        if (table_q[update_idx] != 2'b00) begin
          table_q[update_idx] <= table_q[update_idx] - 2'b01;
        end
      end
    end
  end

  // back end reports word aligned branch addresses
  a_update_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    do_update |-> (update_i.pc[1:0] == 2'b00));

endmodule

//--- logic/fetch_queue.sv
module fetch_queue
  import frontend_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         push_i,
  input  fetch_entry_t entry_i,
  input  logic         flush_i,
  output logic         valid_o,
  output fetch_entry_t entry_o,
  input  logic         ready_i,
  output logic         almost_full_o,
  output logic         empty_o
);

  localparam int unsigned PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CW = $clog2(QUEUE_DEPTH + 1);

  // storage
  fetch_entry_t  mem_q [QUEUE_DEPTH];
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_q;
  logic [CW-1:0] count_q;
  logic          pop;
  logic          full;

  // ----------------------------------------
  // status
  // ----------------------------------------
  assign empty_o       = (count_q == '0);
  assign full          = (count_q == CW'(QUEUE_DEPTH));
  // one slot left
  assign almost_full_o = (count_q == CW'(QUEUE_DEPTH - 1));

  // head entry toward decode
  assign valid_o = !empty_o;
  assign entry_o = mem_q[rd_ptr_q];
  assign pop     = valid_o && ready_i;

  // payload write
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // ----------------------------------------
  // pointers and level
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // a pop in the flush cycle has already transferred
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        // wrap at depth, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CW'(push_i) - CW'(pop);
    end
  end

  // fetch control reserves a slot before each request
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full);

endmodule

//--- logic/frontend_top.sv
module frontend_top
  import frontend_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned BHT_ENTRIES = 16
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  addr_t        boot_addr_i,
  // instruction memory request
  output logic         imem_req_valid_o,
  output imem_req_t    imem_req_o,
  input  logic         imem_req_ready_i,
  // instruction memory response
  input  logic         imem_rsp_valid_i,
  input  imem_rsp_t    imem_rsp_i,
  // toward decode
  output logic         fetch_valid_o,
  output fetch_entry_t fetch_entry_o,
  input  logic         fetch_ready_i,
  // resolved branches from the back end
  input  resolve_t     resolve_i
);

  addr_t        pc;
  addr_t        next_pc;
  addr_t        offset;
  logic         is_branch;
  logic         is_jal;
  logic         bht_taken;
  logic         pred_taken;
  logic         mispredict;
  logic         accept;
  logic         advance_pc;
  logic         flush;
  logic         q_almost_full;
  logic         q_empty;
  fetch_entry_t entry_in;

  // redirect whenever the back end flags a wrong guess
  assign mispredict = resolve_i.valid && resolve_i.mispredict;

  // ----------------------------------------
  // control
  // ----------------------------------------
  fetch_ctrl #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_fetch_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_ready_i       (imem_req_ready_i),
    .rsp_valid_i       (imem_rsp_valid_i),
    .mispredict_i      (mispredict),
    .queue_full_slots_i(q_almost_full),
    .queue_empty_i     (q_empty),
    .req_valid_o       (imem_req_valid_o),
    .accept_o          (accept),
    .advance_pc_o      (advance_pc),
    .flush_o           (flush)
  );

  pc_gen i_pc_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .boot_addr_i  (boot_addr_i),
    .advance_i    (advance_pc),
    .next_pc_i    (next_pc),
    .redirect_i   (mispredict),
    .redirect_pc_i(resolve_i.target),
    .pc_o         (pc)
  );

  // pc stays on the outstanding request until its response is taken
  assign imem_req_o.addr = pc;

  // ----------------------------------------
  // prediction
  // ----------------------------------------
  instr_scan i_instr_scan (
    .instr_i    (imem_rsp_i.data),
    .is_branch_o(is_branch),
    .is_jal_o   (is_jal),
    .offset_o   (offset)
  );

  branch_history #(
    .BHT_ENTRIES(BHT_ENTRIES)
  ) i_branch_history (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lookup_pc_i(pc),
    .update_i   (resolve_i),
    .taken_o    (bht_taken)
  );

  // jal always taken, branches follow the counter msb
  assign pred_taken = is_jal || (is_branch && bht_taken);
  assign next_pc    = pred_taken ? (pc + offset) : (pc + 32'd4);

  // ----------------------------------------
  // queue toward decode
  // ----------------------------------------
  assign entry_in.pc         = pc;
  assign entry_in.instr      = imem_rsp_i.data;
  assign entry_in.pred_taken = pred_taken;

  fetch_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_fetch_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (accept),
    .entry_i      (entry_in),
    .flush_i      (flush),
    .valid_o      (fetch_valid_o),
    .entry_o      (fetch_entry_o),
    .ready_i      (fetch_ready_i),
    .almost_full_o(q_almost_full),
    .empty_o      (q_empty)
  );

endmodule

//--- verification/frontend_checker.sv
module frontend_checker
  import frontend_pkg::*;
#(
  parameter int unsigned BHT_ENTRIES = 16,
  parameter int unsigned PROG_WORDS  = 16,
  parameter addr_t       PROG_BASE   = 32'h0000_0100
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  addr_t        boot_addr_i,
  input  instr_t       prog_i [PROG_WORDS],
  input  logic [2:0]   phase_i,
  input  logic         imem_req_valid_i,
  input  logic         fetch_valid_i,
  input  fetch_entry_t fetch_entry_i,
  input  logic         fetch_ready_i,
  input  resolve_t     resolve_i,
  output int           errors_o,
  output int           checked_o
);

  localparam int unsigned IW = $clog2(BHT_ENTRIES);
  localparam int unsigned PW = $clog2(PROG_WORDS);

  typedef struct packed {
    logic  taken;
    addr_t next_pc;
  } pred_t;

  // counter mirror, same indexing as the table in the DUT
  ctr_t  mirror [BHT_ENTRIES];
  addr_t exp_pc;
  logic  flush_seen;
  int    errors = 0;
  int    checked = 0;

  assign errors_o  = errors;
  assign checked_o = checked;

  function automatic string phase_name(input logic [2:0] p);
    case (p)
      3'd0:    return "boot";
      3'd1:    return "jal_flow";
      3'd2:    return "branch_train";
      3'd3:    return "backpressure";
      default: return "redirect";
    endcase
  endfunction

  // ----------------------------------------
  // reference prediction
  // ----------------------------------------
  function automatic pred_t ref_predict(input addr_t pc, input instr_t instr, input ctr_t ctr);
    pred_t p;
    addr_t imm_j;
    addr_t imm_b;
    // J and B immediates, sign taken from bit 31
    imm_j = addr_t'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
    imm_b = addr_t'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
    p.taken   = 1'b0;
    p.next_pc = pc + 32'd4;
    if (instr[6:0] == OPC_JAL) begin
      p.taken   = 1'b1;
      p.next_pc = pc + imm_j;
    end else if (instr[6:0] == OPC_BRANCH && ctr[1]) begin
      p.taken   = 1'b1;
      p.next_pc = pc + imm_b;
    end
    return p;
  endfunction

  task automatic compare_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch in %s: %s expected %h actual %h", phase_name(phase_i), what, exp, act);
    end
  endtask

  // ----------------------------------------
  // per cycle comparison
  // ----------------------------------------
  always @(posedge clk_i) begin
    pred_t         pred;
    instr_t        exp_instr;
    addr_t         off;
    logic [IW-1:0] idx;
    if (!rst_ni) begin
      // weakly not taken everywhere
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        mirror[i] = 2'b01;
      end
      exp_pc     = boot_addr_i;
      flush_seen = 1'b0;
      if (fetch_valid_i || imem_req_valid_i) begin
        errors++;
        $display("fetch_valid_o or imem_req_valid_o is high during reset");
      end
    end else begin
      // queue must be empty one cycle after a redirect
      if (flush_seen && fetch_valid_i) begin
        errors++;
        $display("fetch_valid_o is high in the cycle after a mispredict (%s)",
                 phase_name(phase_i));
      end
      if (fetch_valid_i && fetch_ready_i) begin
        off = exp_pc - PROG_BASE;
        if (off >= PROG_WORDS * 4 || off[1:0] != 2'b00) begin
          errors++;
          $display("expected pc %h lies outside the program", exp_pc);
        end else begin
          exp_instr = prog_i[off[PW+1:2]];
          pred = ref_predict(exp_pc, exp_instr, mirror[exp_pc[IW+1:2]]);
          compare_word("pc", exp_pc, fetch_entry_i.pc);
          compare_word("instr", exp_instr, fetch_entry_i.instr);
          compare_word("pred_taken", 32'(pred.taken), 32'(fetch_entry_i.pred_taken));
          // follow the reference path, not the delivered one
          exp_pc = pred.next_pc;
        end
        checked++;
      end
      // an entry taken in the same cycle still used the old counter
      idx = resolve_i.pc[IW+1:2];
      if (resolve_i.valid && resolve_i.is_branch) begin
        if (resolve_i.taken && mirror[idx] != 2'b11) begin
          mirror[idx] = mirror[idx] + 2'b01;
        end else if (!resolve_i.taken && mirror[idx] != 2'b00) begin
          mirror[idx] = mirror[idx] - 2'b01;
        end
      end
      flush_seen = resolve_i.valid && resolve_i.mispredict;
      if (flush_seen) begin
        exp_pc = resolve_i.target;
      end
    end
  end

endmodule

//--- verification/tb_frontend.sv
module tb_frontend
  import frontend_pkg::*;
();

  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned BHT_ENTRIES = 16;
  localparam int unsigned PROG_WORDS  = 16;
  localparam int unsigned PW          = $clog2(PROG_WORDS);
  localparam addr_t       PROG_BASE   = 32'h0000_0100;
  // the two conditional branches of the program
  localparam addr_t       BR_A        = PROG_BASE + 32'd12;
  localparam addr_t       BR_B        = PROG_BASE + 32'd32;
  localparam logic [31:0] SEED        = 32'd28067;

  // test lengths in delivered entries
  localparam int N_JAL            = 30;
  localparam int N_TRAIN          = 5;
  localparam int N_TRAIN_STEP     = 10;
  localparam int N_BACKPRESSURE   = 40;
  localparam int N_REDIRECTS      = 10;
  localparam int N_AFTER_REDIRECT = 4;
  localparam int TOTAL_ENTRIES    = 1 + N_JAL + N_TRAIN * N_TRAIN_STEP + N_BACKPRESSURE
                                    + N_REDIRECTS * N_AFTER_REDIRECT;
  // about 20 cycles per entry at worst plus reset and redirect gaps
  localparam int MAX_CYCLES       = (TOTAL_ENTRIES + 39) * 20;

  localparam logic [2:0] PH_BOOT         = 3'd0;
  localparam logic [2:0] PH_JAL          = 3'd1;
  localparam logic [2:0] PH_TRAIN        = 3'd2;
  localparam logic [2:0] PH_BACKPRESSURE = 3'd3;
  localparam logic [2:0] PH_REDIRECT     = 3'd4;

  logic         clk_i = 1'b0;
  logic         rst_ni = 1'b0;
  addr_t        boot_addr_i = PROG_BASE + 32'd8;
  logic         imem_req_valid_o;
  imem_req_t    imem_req_o;
  logic         imem_req_ready_i = 1'b0;
  logic         imem_rsp_valid_i = 1'b0;
  imem_rsp_t    imem_rsp_i = '0;
  logic         fetch_valid_o;
  fetch_entry_t fetch_entry_o;
  logic         fetch_ready_i = 1'b0;
  resolve_t     resolve_i = '0;

  instr_t       prog [PROG_WORDS];
  logic [2:0]   phase = PH_BOOT;
  logic [31:0]  bus_rng = SEED;
  logic [31:0]  stim_rng = SEED;
  int           delivered = 0;
  int           tb_errors = 0;
  int           cycles = 0;
  int           chk_errors;
  int           chk_checked;
  // memory model with one request in flight
  logic         mem_pend = 1'b0;
  logic [1:0]   mem_wait;
  addr_t        mem_addr;

  always #10 clk_i = ~clk_i;

  // port names match the DUT
  frontend_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .BHT_ENTRIES(BHT_ENTRIES)
  ) uut (.*);

  frontend_checker #(
    .BHT_ENTRIES(BHT_ENTRIES),
    .PROG_WORDS (PROG_WORDS),
    .PROG_BASE  (PROG_BASE)
  ) i_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .boot_addr_i     (boot_addr_i),
    .prog_i          (prog),
    .phase_i         (phase),
    .imem_req_valid_i(imem_req_valid_o),
    .fetch_valid_i   (fetch_valid_o),
    .fetch_entry_i   (fetch_entry_o),
    .fetch_ready_i   (fetch_ready_i),
    .resolve_i       (resolve_i),
    .errors_o        (chk_errors),
    .checked_o       (chk_checked)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // addi x1, x0, imm
  function automatic instr_t addi_word(input logic [11:0] imm);
    return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
  endfunction

  function automatic instr_t jal_word(input int off);
    logic [20:0] i;
    i = off[20:0];
    return {i[20], i[10:1], i[11], i[19:12], 5'd0, OPC_JAL};
  endfunction

  // beq x0, x0
  function automatic instr_t beq_word(input int off);
    logic [12:0] i;
    i = off[12:0];
    return {i[12], i[10:5], 5'd0, 5'd0, 3'b000, i[4:1], i[11], OPC_BRANCH};
  endfunction

  task automatic wait_entries(input int n);
    int target;
    target = delivered + n;
    while (delivered < target) @(posedge clk_i);
  endtask

  // caller sits on a rising edge and resolve is valid for one cycle
  task automatic drive_resolve(input resolve_t r);
    resolve_i <= r;
    @(posedge clk_i);
    resolve_i <= '0;
  endtask

  // mispredicted branch sends the frontend to the resolved path
  task automatic train(input addr_t pc, input addr_t target, input logic taken);
    resolve_t r;
    r = '0;
    r.valid      = 1'b1;
    r.is_branch  = 1'b1;
    r.taken      = taken;
    r.mispredict = 1'b1;
    r.pc         = pc;
    r.target     = taken ? target : pc + 32'd4;
    drive_resolve(r);
    wait_entries(N_TRAIN_STEP);
  endtask

  task automatic report_and_finish(input logic timed_out);
    int total;
    total = chk_errors + tb_errors + int'(timed_out);
    $display("errors: %0d checker, %0d testbench, %0d timeout; entries checked: %0d",
             chk_errors, tb_errors, int'(timed_out), chk_checked);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------
  // memory model and decode ready
  // ----------------------------------------
  always @(posedge clk_i) begin
    addr_t off;
    if (!rst_ni) begin
      mem_pend = 1'b0;
      imem_rsp_valid_i <= 1'b0;
    end else begin
      bus_rng = lcg_next(bus_rng);
      imem_req_ready_i <= (bus_rng[21:20] != 2'b00);
      // decode mostly stalls under back-pressure
      if (phase == PH_BACKPRESSURE) begin
        fetch_ready_i <= (bus_rng[13:12] == 2'b00);
      end else begin
        fetch_ready_i <= (bus_rng[13:12] != 2'b00);
      end
      if (fetch_valid_o && fetch_ready_i) begin
        delivered <= delivered + 1;
      end
      imem_rsp_valid_i <= 1'b0;
      if (imem_req_valid_o && imem_req_ready_i) begin
        if (mem_pend) begin
          tb_errors++;
          $display("second memory request while one is outstanding");
        end
        mem_pend = 1'b1;
        // latency of 1 to 3 cycles
        mem_wait = (bus_rng[5:4] == 2'b11) ? 2'd0 : bus_rng[5:4];
        mem_addr = imem_req_o.addr;
      end
      if (mem_pend) begin
        if (mem_wait == 2'd0) begin
          off = mem_addr - PROG_BASE;
          imem_rsp_valid_i <= 1'b1;
          if (off < PROG_WORDS * 4 && off[1:0] == 2'b00) begin
            imem_rsp_i.data <= prog[off[PW+1:2]];
          end else begin
            tb_errors++;
            $display("memory request to %h outside the program", mem_addr);
            imem_rsp_i.data <= ~mem_addr;
          end
          mem_pend = 1'b0;
        end else begin
          mem_wait = mem_wait - 2'd1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      @(negedge clk_i);
      report_and_finish(1'b1);
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    resolve_t r;
    // numbered addi words with jumps and two forward branches
    for (int k = 0; k < PROG_WORDS; k++) begin
      prog[k] = addi_word(12'(k));
    end
    prog[3]  = beq_word(12);
    prog[5]  = jal_word(12);
    prog[8]  = beq_word(16);
    prog[10] = jal_word(12);
    prog[14] = jal_word(-56);
    prog[15] = jal_word(-60);

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait_entries(1);

    phase <= PH_JAL;
    wait_entries(N_JAL);

    // BR_A goes to taken and back while BR_B goes to taken
    phase <= PH_TRAIN;
    train(BR_A, PROG_BASE + 32'd24, 1'b1);
    train(BR_A, PROG_BASE + 32'd24, 1'b1);
    train(BR_B, PROG_BASE + 32'd48, 1'b1);
    train(BR_A, PROG_BASE + 32'd24, 1'b0);
    train(BR_A, PROG_BASE + 32'd24, 1'b0);

    phase <= PH_BACKPRESSURE;
    wait_entries(N_BACKPRESSURE);

    // even rounds hit an outstanding request and odd rounds wait a random gap
    phase <= PH_REDIRECT;
    for (int n = 0; n < N_REDIRECTS; n++) begin
      stim_rng = lcg_next(stim_rng);
      if (n[0]) begin
        repeat (stim_rng[10:8]) @(posedge clk_i);
      end else begin
        do @(posedge clk_i); while (!(imem_req_valid_o && imem_req_ready_i));
      end
      r = '0;
      r.valid      = 1'b1;
      r.taken      = 1'b1;
      r.mispredict = 1'b1;
      r.pc         = PROG_BASE;
      r.target     = PROG_BASE + 32'({stim_rng[23:20], 2'b00});
      drive_resolve(r);
      wait_entries(N_AFTER_REDIRECT);
    end

    @(negedge clk_i);
    report_and_finish(1'b0);
  end

endmodule

//--- frontend.f
logic/frontend_pkg.sv
logic/fetch_ctrl.sv
logic/pc_gen.sv
logic/instr_scan.sv
logic/branch_history.sv
logic/fetch_queue.sv
logic/frontend_top.sv
verification/frontend_checker.sv
verification/tb_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build the frontend testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f frontend.f --top-module tb_frontend -o sim_frontend

# a failing run still leaves its log for the search below
status=0
./obj_dir/sim_frontend > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, exit status $status"
  exit 1
fi
